/* flist.f */
+incdir+rtl
rtl/rv_decode_pkg.sv
rtl/regfile.sv
rtl/imm_gen.sv
rtl/ctrl_unit.sv
rtl/hazard_unit.sv
rtl/id_stage.sv
rtl/decode_top.sv
sim/decode_sva.sv
sim/decode_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the decode testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module decode_tb -f flist.f -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed."
	exit 1
fi

output="$(./obj_dir/Vdecode_tb)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status."
	exit 1
fi

if echo "$output" | grep -q "All tests passed"; then
	exit 0
else
	exit 1
fi

/* sim/decode_tb.sv */
`default_nettype none

`include "rv_decode_cfg.svh"

module decode_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int NROWS = 23;

	localparam logic [6:0] OP_LUI = 7'b0110111;
	localparam logic [6:0] OP_AUIPC = 7'b0010111;
	localparam logic [6:0] OP_JAL = 7'b1101111;
	localparam logic [6:0] OP_JALR = 7'b1100111;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_LOAD = 7'b0000011;
	localparam logic [6:0] OP_STORE = 7'b0100011;
	localparam logic [6:0] OP_IMM = 7'b0010011;
	localparam logic [6:0] OP_REG = 7'b0110011;

	localparam logic [3:0] ALU_ADD = 4'd0;
	localparam logic [3:0] ALU_SUB = 4'd1;
	localparam logic [3:0] ALU_SLT = 4'd3;
	localparam logic [3:0] ALU_XOR = 4'd5;
	localparam logic [3:0] ALU_SRA = 4'd7;
	localparam logic [3:0] ALU_OR = 4'd8;
	localparam logic [3:0] ALU_AND = 4'd9;
	localparam logic [3:0] ALU_PASSB = 4'd10;
	localparam logic [1:0] WB_ALU = 2'd0;
	localparam logic [1:0] WB_MEM = 2'd1;
	localparam logic [1:0] WB_PC4 = 2'd2;

	typedef struct packed {
		logic [31:0] inst;
		logic valid;
		logic flush;
		logic stall;
		logic wb_we;
		logic [4:0] wb_rd;
		logic [31:0] imm;
		rv_decode_pkg::ctrl_t ctrl;
	} row_t;

	logic clk_i;
	logic rst_ni;
	rv_decode_pkg::inst_u inst_i;
	logic [`RV_XLEN-1:0] pc_i;
	logic [`RV_XLEN-1:0] pc4_i;
	logic hit_i;
	logic valid_i;
	logic flush_i;
	rv_decode_pkg::wb_t wb_i;
	rv_decode_pkg::id_ex_t ex_o;
	logic stall_o;

	row_t rows [NROWS];
	logic [`RV_XLEN-1:0] reg_model [`RV_NREGS];
	integer seed;

	decode_top decode_top_inst (
		.clk_i(clk_i),
		.rst_ni(rst_ni),
		.inst_i(inst_i),
		.pc_i(pc_i),
		.pc4_i(pc4_i),
		.hit_i(hit_i),
		.valid_i(valid_i),
		.flush_i(flush_i),
		.wb_i(wb_i),
		.ex_o(ex_o),
		.stall_o(stall_o)
	);

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {f7, rs2, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
	endfunction

	function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
	endfunction

	function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] op);
		return {imm, rd, op};
	endfunction

	function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
	endfunction

	// Flag order is {b_sel, a_sel, mem_rw, br_un, reg_wen, is_ls}.
	function automatic rv_decode_pkg::ctrl_t ctl(input logic [3:0] alu, input logic [1:0] wb,
		input logic [5:0] flags);
		rv_decode_pkg::ctrl_t c;
		c.alu_sel = rv_decode_pkg::alu_sel_e'(alu);
		c.wb_sel = rv_decode_pkg::wb_sel_e'(wb);
		{c.b_sel, c.a_sel, c.mem_rw, c.br_un, c.reg_wen, c.is_ls} = flags;
		return c;
	endfunction

	// Control bits are {valid, flush, expected stall}.
	function automatic row_t make_row(input logic [31:0] inst, input logic [2:0] vfs,
		input logic we, input logic [4:0] rd, input logic [31:0] imm,
		input rv_decode_pkg::ctrl_t ctrl);
		row_t r;
		r.inst = inst;
		{r.valid, r.flush, r.stall} = vfs;
		r.wb_we = we;
		r.wb_rd = rd;
		r.imm = imm;
		r.ctrl = ctrl;
		return r;
	endfunction

	// Register read as decode sees it, with a same-cycle write forwarded.
	function automatic logic [31:0] model_read(input logic [4:0] addr, input logic we,
		input logic [4:0] rd, input logic [31:0] data);
		if (addr == 5'd0)
			return '0;
		if (we && rd == addr)
			return data;
		return reg_model[addr];
	endfunction

	task automatic fill_table();
		rows[0] = make_row(enc_i(12'd5, 5'd0, 3'b000, 5'd1, OP_IMM), 3'b100, 1'b1, 5'd1,
			32'h5, ctl(ALU_ADD, WB_ALU, 6'b100010));
		rows[1] = make_row(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3, OP_REG), 3'b100, 1'b1, 5'd2,
			32'h2, ctl(ALU_ADD, WB_ALU, 6'b000010)); // x2 comes through the bypass.
		rows[2] = make_row(enc_r(7'h20, 5'd1, 5'd3, 3'b000, 5'd4, OP_REG), 3'b100, 1'b1, 5'd0,
			32'h401, ctl(ALU_SUB, WB_ALU, 6'b000010));
		rows[3] = make_row(enc_r(7'h20, 5'd0, 5'd2, 3'b101, 5'd5, OP_REG), 3'b100, 1'b1, 5'd0,
			32'h400, ctl(ALU_SRA, WB_ALU, 6'b000010));
		rows[4] = make_row(enc_i({7'h20, 5'd3}, 5'd1, 3'b101, 5'd6, OP_IMM), 3'b100, 1'b1,
			5'd7, 32'h403, ctl(ALU_SRA, WB_ALU, 6'b100010));
		rows[5] = make_row(enc_s(12'hff8, 5'd2, 5'd1, 3'b010), 3'b100, 1'b0, 5'd0,
			32'hfffffff8, ctl(ALU_ADD, WB_ALU, 6'b101001));
		rows[6] = make_row(enc_b(13'h1ff0, 5'd2, 5'd1, 3'b110), 3'b100, 1'b0, 5'd0,
			32'hfffffff0, ctl(ALU_ADD, WB_ALU, 6'b110100));
		rows[7] = make_row(enc_b(13'h0800, 5'd4, 5'd3, 3'b000), 3'b100, 1'b1, 5'd9,
			32'h800, ctl(ALU_ADD, WB_ALU, 6'b110000));
		rows[8] = make_row(enc_u(20'habcde, 5'd8, OP_LUI), 3'b100, 1'b0, 5'd0,
			32'habcde000, ctl(ALU_PASSB, WB_ALU, 6'b100010));
		rows[9] = make_row(enc_u(20'h12345, 5'd9, OP_AUIPC), 3'b100, 1'b0, 5'd0,
			32'h12345000, ctl(ALU_ADD, WB_ALU, 6'b110010));
		rows[10] = make_row(enc_j(21'h100802, 5'd1), 3'b100, 1'b0, 5'd0,
			32'hfff00802, ctl(ALU_ADD, WB_PC4, 6'b110010));
		rows[11] = make_row(enc_i(12'd12, 5'd5, 3'b000, 5'd10, OP_JALR), 3'b100, 1'b0, 5'd0,
			32'hc, ctl(ALU_ADD, WB_PC4, 6'b100010));
		rows[12] = make_row(enc_i(12'd4, 5'd1, 3'b010, 5'd11, OP_LOAD), 3'b100, 1'b0, 5'd0,
			32'h4, ctl(ALU_ADD, WB_MEM, 6'b100011));
		rows[13] = make_row(enc_r(7'h00, 5'd2, 5'd11, 3'b000, 5'd12, OP_REG), 3'b101, 1'b0,
			5'd0, 32'h2, ctl(ALU_ADD, WB_ALU, 6'b000010)); // Load-use, one bubble.
		rows[14] = make_row(enc_r(7'h00, 5'd2, 5'd11, 3'b000, 5'd12, OP_REG), 3'b100, 1'b0,
			5'd0, 32'h2, ctl(ALU_ADD, WB_ALU, 6'b000010));
		rows[15] = make_row(enc_i(12'd0, 5'd1, 3'b010, 5'd0, OP_LOAD), 3'b100, 1'b0, 5'd0,
			32'h0, ctl(ALU_ADD, WB_MEM, 6'b100011));
		rows[16] = make_row(enc_r(7'h00, 5'd1, 5'd0, 3'b000, 5'd13, OP_REG), 3'b100, 1'b0,
			5'd0, 32'h1, ctl(ALU_ADD, WB_ALU, 6'b000010));
		rows[17] = make_row(enc_i(12'd8, 5'd2, 3'b010, 5'd14, OP_LOAD), 3'b100, 1'b0, 5'd0,
			32'h8, ctl(ALU_ADD, WB_MEM, 6'b100011));
		rows[18] = make_row(enc_i(12'd0, 5'd14, 3'b010, 5'd15, OP_LOAD), 3'b110, 1'b0,
			5'd0, 32'h0, ctl(ALU_ADD, WB_MEM, 6'b100011)); // Flush wins over the hazard.
		rows[19] = make_row(enc_r(7'h00, 5'd2, 5'd15, 3'b110, 5'd16, OP_REG), 3'b100, 1'b0,
			5'd0, 32'h2, ctl(ALU_OR, WB_ALU, 6'b000010)); // Reads the flushed load's rd.
		rows[20] = make_row(enc_r(7'h00, 5'd2, 5'd1, 3'b100, 5'd16, OP_REG), 3'b000, 1'b0,
			5'd0, 32'h2, ctl(ALU_XOR, WB_ALU, 6'b000010));
		rows[21] = make_row(enc_r(7'h00, 5'd6, 5'd7, 3'b111, 5'd17, OP_REG), 3'b100, 1'b1,
			5'd7, 32'h6, ctl(ALU_AND, WB_ALU, 6'b000010));
		rows[22] = make_row(enc_r(7'h00, 5'd3, 5'd7, 3'b010, 5'd18, OP_REG), 3'b100, 1'b0,
			5'd0, 32'h3, ctl(ALU_SLT, WB_ALU, 6'b000010));
	endtask

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Some tests failed");
		$fatal(1, "Simulation stopped at the first error.");
	endtask

	task automatic check_field(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		assert (act === exp)
		else
			report_failure($sformatf("[FAIL] %s expected %h actual %h", name, exp, act));
	endtask

	task automatic check_record(input rv_decode_pkg::id_ex_t exp);
		check_field("ex_o.rs1", exp.rs1, ex_o.rs1);
		check_field("ex_o.rs2", exp.rs2, ex_o.rs2);
		check_field("ex_o.imm", exp.imm, ex_o.imm);
		check_field("ex_o.pc", exp.pc, ex_o.pc);
		check_field("ex_o.pc4", exp.pc4, ex_o.pc4);
		check_field("ex_o.inst", exp.inst, ex_o.inst);
		check_field("ex_o.rd", {27'b0, exp.rd}, {27'b0, ex_o.rd});
		check_field("ex_o.hit", {31'b0, exp.hit}, {31'b0, ex_o.hit});
		check_field("ex_o.ctrl", {20'b0, exp.ctrl}, {20'b0, ex_o.ctrl});
	endtask

	initial begin
		clk_i = 1'b0;
		forever #20 clk_i = ~clk_i;
	end

	initial begin
		#((NROWS + 20) * 40);
		report_failure("Timeout: the table did not finish in the expected time.");
	end

	initial begin
		rv_decode_pkg::id_ex_t exp_rec;
		rv_decode_pkg::id_ex_t prev_rec;
		logic [31:0] wb_data;
		logic [31:0] inst;
		logic [31:0] pc;
		seed = 32'hd804a057;
		rst_ni = 1'b0;
		inst_i = '0;
		pc_i = '0;
		pc4_i = '0;
		hit_i = 1'b0;
		valid_i = 1'b0;
		flush_i = 1'b0;
		wb_i = '0;
		for (int r = 0; r < `RV_NREGS; r++)
			reg_model[r] = '0;
		fill_table();
		repeat (5) @(posedge clk_i);
		rst_ni <= 1'b1;
		prev_rec = '0; // The first check sees the record left by reset.
		for (int i = 0; i < NROWS; i++) begin
			@(posedge clk_i);
			wb_data = $random(seed);
			inst = rows[i].inst;
			pc = 32'h1000 + 32'(i) * 32'd4;
			inst_i <= inst;
			pc_i <= pc;
			pc4_i <= pc + 32'd4;
			hit_i <= i[0];
			valid_i <= rows[i].valid;
			flush_i <= rows[i].flush;
			wb_i.we <= rows[i].wb_we;
			wb_i.rd <= rows[i].wb_rd;
			wb_i.data <= wb_data;
			if (!rows[i].valid || rows[i].flush || rows[i].stall) begin
				exp_rec = '0;
			end else begin
				exp_rec.rs1 = model_read(inst[19:15], rows[i].wb_we, rows[i].wb_rd, wb_data);
				exp_rec.rs2 = model_read(inst[24:20], rows[i].wb_we, rows[i].wb_rd, wb_data);
				exp_rec.imm = rows[i].imm;
				exp_rec.pc = pc;
				exp_rec.pc4 = pc + 32'd4;
				exp_rec.inst = inst;
				exp_rec.rd = inst[11:7];
				exp_rec.hit = i[0];
				exp_rec.ctrl = rows[i].ctrl;
			end
			if (rows[i].wb_we && rows[i].wb_rd != 5'd0)
				reg_model[rows[i].wb_rd] = wb_data; // x0 never keeps a value.
			@(negedge clk_i);
			check_field("stall_o", {31'b0, rows[i].stall}, {31'b0, stall_o});
			check_record(prev_rec);
			prev_rec = exp_rec;
		end
		@(posedge clk_i);
		valid_i <= 1'b0;
		wb_i.we <= 1'b0;
		@(negedge clk_i);
		check_record(prev_rec);
		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire

/* sim/decode_sva.sv */
`default_nettype none

module decode_sva (
	input logic clk_i,
	input logic rst_ni,
	input logic flush_i,
	input logic stall_o,
	input rv_decode_pkg::id_ex_t ex_o
);

	timeunit 1ns;
	timeprecision 1ps;

	// A stalled instruction leaves a bubble behind it.
	stall_gives_bubble: assert property (@(posedge clk_i) disable iff (!rst_ni)
		stall_o |=> ex_o == '0)
		else $error("Stall was not followed by a NOP record.");

	reset_clears_record: assert property (@(posedge clk_i) !rst_ni |-> ex_o == '0)
		else $error("ID/EX record is not zero during reset.");

	// The flushed cycle leaves a NOP in execute, so nothing can depend on it.
	no_stall_after_flush: assert property (@(posedge clk_i) disable iff (!rst_ni)
		flush_i |=> !stall_o)
		else $error("Stall raised in the cycle after a flush.");

endmodule

bind decode_top decode_sva decode_sva_inst (
	.clk_i(clk_i),
	.rst_ni(rst_ni),
	.flush_i(flush_i),
	.stall_o(stall_o),
	.ex_o(ex_o)
);

`default_nettype wire

/* rtl/decode_top.sv */
`default_nettype none

`include "rv_decode_cfg.svh"

module decode_top (
	input logic clk_i,
	input logic rst_ni,
	input rv_decode_pkg::inst_u inst_i,
	input logic [`RV_XLEN-1:0] pc_i,
	input logic [`RV_XLEN-1:0] pc4_i,
	input logic hit_i,
	input logic valid_i,
	input logic flush_i,
	input rv_decode_pkg::wb_t wb_i,
	output rv_decode_pkg::id_ex_t ex_o,
	output logic stall_o
);

	logic enable;
	logic bubble;

	hazard_unit hazard_unit_inst (
		.valid_i(valid_i),
		.flush_i(flush_i),
		.inst_i(inst_i),
		.ex_ctrl_i(ex_o.ctrl), // Compared against the instruction now in decode.
		.ex_rd_i(ex_o.rd),
		.enable_o(enable),
		.bubble_o(bubble),
		.stall_o(stall_o)
	);

	id_stage id_stage_inst (
		.clk_i(clk_i),
		.rst_ni(rst_ni),
		.inst_i(inst_i),
		.pc_i(pc_i),
		.pc4_i(pc4_i),
		.hit_i(hit_i),
		.wb_i(wb_i),
		.enable_i(enable),
		.bubble_i(bubble),
		.ex_o(ex_o)
	);

endmodule

`default_nettype wire

/* rtl/id_stage.sv */
`default_nettype none

`include "rv_decode_cfg.svh"

module id_stage (
	input logic clk_i,
	input logic rst_ni,
	input rv_decode_pkg::inst_u inst_i,
	input logic [`RV_XLEN-1:0] pc_i,
	input logic [`RV_XLEN-1:0] pc4_i,
	input logic hit_i,
	input rv_decode_pkg::wb_t wb_i,
	input logic enable_i,
	input logic bubble_i,
	output rv_decode_pkg::id_ex_t ex_o
);

	logic [`RV_XLEN-1:0] rs1_data;
	logic [`RV_XLEN-1:0] rs2_data;
	logic [`RV_XLEN-1:0] imm;
	rv_decode_pkg::ctrl_t ctrl;
	rv_decode_pkg::imm_sel_e imm_sel;
	rv_decode_pkg::id_ex_t ex_d;

	regfile regfile_inst (
		.clk_i(clk_i),
		.rst_ni(rst_ni),
		.wb_i(wb_i),
		.rs1_addr_i(inst_i.r_fmt.rs1),
		.rs2_addr_i(inst_i.r_fmt.rs2),
		.rs1_data_o(rs1_data),
		.rs2_data_o(rs2_data)
	);

	imm_gen imm_gen_inst (
		.inst_i(inst_i),
		.imm_sel_i(imm_sel),
		.imm_o(imm)
	);

	ctrl_unit ctrl_unit_inst (
		.inst_i(inst_i),
		.ctrl_o(ctrl),
		.imm_sel_o(imm_sel)
	);

	always_comb begin
		ex_d.rs1 = rs1_data;
		ex_d.rs2 = rs2_data;
		ex_d.imm = imm;
		ex_d.pc = pc_i;
		ex_d.pc4 = pc4_i;
		ex_d.inst = inst_i;
		ex_d.rd = inst_i.r_fmt.rd;
		ex_d.hit = hit_i;
		ex_d.ctrl = ctrl;
	end

	// An all-zero record is the NOP that execute ignores.
	always_ff @(posedge clk_i, negedge rst_ni) begin
		if (!rst_ni)
			ex_o <= '0;
		else if (enable_i)
			ex_o <= bubble_i ? '0 : ex_d;
	end

endmodule

`default_nettype wire

/* rtl/hazard_unit.sv */
`default_nettype none

`include "rv_decode_cfg.svh"

module hazard_unit (
	input logic valid_i,
	input logic flush_i,
	input rv_decode_pkg::inst_u inst_i,
	input rv_decode_pkg::ctrl_t ex_ctrl_i,
	input logic [`RV_REG_AW-1:0] ex_rd_i,
	output logic enable_o,
	output logic bubble_o,
	output logic stall_o
);

	logic ex_is_load;
	logic rd_match;
	logic load_use;

	assign ex_is_load = ex_ctrl_i.is_ls && ex_ctrl_i.wb_sel == rv_decode_pkg::WB_MEM;

	// Loads to x0 produce nothing to wait for.
	assign rd_match = ex_rd_i != '0 &&
		(ex_rd_i == inst_i.r_fmt.rs1 || ex_rd_i == inst_i.r_fmt.rs2);

	assign load_use = valid_i && ex_is_load && rd_match;

	// Execute never pushes back, so the ID/EX register advances every cycle.
	assign enable_o = 1'b1;

	assign bubble_o = flush_i || !valid_i || load_use;
	assign stall_o = load_use && !flush_i; // A flush discards the dependent instruction.

endmodule

`default_nettype wire

/* rtl/ctrl_unit.sv */
`default_nettype none

module ctrl_unit (
	input rv_decode_pkg::inst_u inst_i,
	output rv_decode_pkg::ctrl_t ctrl_o,
	output rv_decode_pkg::imm_sel_e imm_sel_o
);

	localparam logic [6:0] OP_LUI = 7'b0110111;
	localparam logic [6:0] OP_AUIPC = 7'b0010111;
	localparam logic [6:0] OP_JAL = 7'b1101111;
	localparam logic [6:0] OP_JALR = 7'b1100111;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_LOAD = 7'b0000011;
	localparam logic [6:0] OP_STORE = 7'b0100011;
	localparam logic [6:0] OP_IMM = 7'b0010011;
	localparam logic [6:0] OP_REG = 7'b0110011;

	logic alt; // funct7 bit 5 selects SUB and SRA.

	function automatic rv_decode_pkg::alu_sel_e alu_op(input logic [2:0] funct3,
		input logic alt_op);
		rv_decode_pkg::alu_sel_e op;
		case (funct3)
			3'b000: op = alt_op ? rv_decode_pkg::ALU_SUB : rv_decode_pkg::ALU_ADD;
			3'b001: op = rv_decode_pkg::ALU_SLL;
			3'b010: op = rv_decode_pkg::ALU_SLT;
			3'b011: op = rv_decode_pkg::ALU_SLTU;
			3'b100: op = rv_decode_pkg::ALU_XOR;
			3'b101: op = alt_op ? rv_decode_pkg::ALU_SRA : rv_decode_pkg::ALU_SRL;
			3'b110: op = rv_decode_pkg::ALU_OR;
			default: op = rv_decode_pkg::ALU_AND;
		endcase
		return op;
	endfunction

	assign alt = inst_i.r_fmt.funct7[5];

	always_comb begin
		ctrl_o = '0;
		imm_sel_o = rv_decode_pkg::IMM_I;
		case (inst_i.r_fmt.opcode)
			OP_LUI: begin
				ctrl_o.alu_sel = rv_decode_pkg::ALU_PASSB;
				ctrl_o.b_sel = 1'b1;
				ctrl_o.reg_wen = 1'b1;
				imm_sel_o = rv_decode_pkg::IMM_U;
			end
			OP_AUIPC, OP_JAL: begin
				ctrl_o.a_sel = 1'b1;
				ctrl_o.b_sel = 1'b1;
				ctrl_o.reg_wen = 1'b1;
				if (inst_i.r_fmt.opcode == OP_JAL) begin
					ctrl_o.wb_sel = rv_decode_pkg::WB_PC4;
					imm_sel_o = rv_decode_pkg::IMM_J;
				end else begin
					imm_sel_o = rv_decode_pkg::IMM_U;
				end
			end
			OP_JALR: begin
				ctrl_o.b_sel = 1'b1;
				ctrl_o.wb_sel = rv_decode_pkg::WB_PC4;
				ctrl_o.reg_wen = 1'b1;
			end
			OP_BRANCH: begin // Target is pc + imm; the compare runs beside the ALU.
				ctrl_o.a_sel = 1'b1;
				ctrl_o.b_sel = 1'b1;
				ctrl_o.br_un = inst_i.b_fmt.funct3[1];
				imm_sel_o = rv_decode_pkg::IMM_B;
			end
			OP_LOAD: begin
				ctrl_o.b_sel = 1'b1;
				ctrl_o.wb_sel = rv_decode_pkg::WB_MEM;
				ctrl_o.reg_wen = 1'b1;
				ctrl_o.is_ls = 1'b1;
			end
			OP_STORE: begin
				ctrl_o.b_sel = 1'b1;
				ctrl_o.mem_rw = 1'b1;
				ctrl_o.is_ls = 1'b1;
				imm_sel_o = rv_decode_pkg::IMM_S;
			end
			OP_IMM: begin
				ctrl_o.alu_sel = alu_op(inst_i.i_fmt.funct3,
					alt && inst_i.i_fmt.funct3 == 3'b101); // Only SRAI uses funct7.
				ctrl_o.b_sel = 1'b1;
				ctrl_o.reg_wen = 1'b1;
			end
			OP_REG: begin
				ctrl_o.alu_sel = alu_op(inst_i.r_fmt.funct3, alt);
				ctrl_o.reg_wen = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

/* rtl/imm_gen.sv */
`default_nettype none

`include "rv_decode_cfg.svh"

module imm_gen (
	input rv_decode_pkg::inst_u inst_i,
	input rv_decode_pkg::imm_sel_e imm_sel_i,
	output logic [`RV_XLEN-1:0] imm_o
);

	always_comb begin
		unique case (imm_sel_i)
			rv_decode_pkg::IMM_I:
				imm_o = {{(`RV_XLEN-12){inst_i.i_fmt.imm[11]}}, inst_i.i_fmt.imm};
			rv_decode_pkg::IMM_S:
				imm_o = {{(`RV_XLEN-12){inst_i.s_fmt.imm_hi[6]}},
					inst_i.s_fmt.imm_hi, inst_i.s_fmt.imm_lo};
			rv_decode_pkg::IMM_B: // Branch offsets are half-word aligned.
				imm_o = {{(`RV_XLEN-12){inst_i.b_fmt.imm12}}, inst_i.b_fmt.imm11,
					inst_i.b_fmt.imm10_5, inst_i.b_fmt.imm4_1, 1'b0};
			rv_decode_pkg::IMM_U:
				imm_o = {inst_i.u_fmt.imm, 12'b0};
			rv_decode_pkg::IMM_J:
				imm_o = {{(`RV_XLEN-20){inst_i.j_fmt.imm20}}, inst_i.j_fmt.imm19_12,
					inst_i.j_fmt.imm11, inst_i.j_fmt.imm10_1, 1'b0};
			default:
				imm_o = '0;
		endcase
	end

endmodule

`default_nettype wire

/* rtl/regfile.sv */
`default_nettype none

`include "rv_decode_cfg.svh"

module regfile (
	input logic clk_i,
	input logic rst_ni,
	input rv_decode_pkg::wb_t wb_i,
	input logic [`RV_REG_AW-1:0] rs1_addr_i,
	input logic [`RV_REG_AW-1:0] rs2_addr_i,
	output logic [`RV_XLEN-1:0] rs1_data_o,
	output logic [`RV_XLEN-1:0] rs2_data_o
);

	logic [`RV_XLEN-1:0] regs [1:`RV_NREGS-1]; // x0 has no storage.

	// A write landing this cycle is forwarded to the reader.
	function automatic logic [`RV_XLEN-1:0] read_port(input logic [`RV_REG_AW-1:0] addr);
		logic [`RV_XLEN-1:0] data;
		if (addr == '0)
			data = '0;
		else if (wb_i.we && wb_i.rd == addr)
			data = wb_i.data;
		else
			data = regs[addr];
		return data;
	endfunction

	always_ff @(posedge clk_i, negedge rst_ni) begin
		if (!rst_ni) begin
			for (int i = 1; i < `RV_NREGS; i++)
				regs[i] <= '0;
		end else if (wb_i.we && wb_i.rd != '0) begin
			regs[wb_i.rd] <= wb_i.data;
		end
	end

	always_comb begin
		rs1_data_o = read_port(rs1_addr_i);
		rs2_data_o = read_port(rs2_addr_i);
	end

endmodule

`default_nettype wire

/* rtl/rv_decode_pkg.sv */
`default_nettype none

`include "rv_decode_cfg.svh"

package rv_decode_pkg;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} s_fmt_t;

	typedef struct packed {
		logic imm12;
		logic [5:0] imm10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic imm11;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm;
		logic [4:0] rd;
		logic [6:0] opcode;
	} u_fmt_t;

	typedef struct packed {
		logic imm20;
		logic [9:0] imm10_1;
		logic imm11;
		logic [7:0] imm19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_fmt_t;

	// One instruction word, seen through each of the base formats.
	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
		s_fmt_t s_fmt;
		b_fmt_t b_fmt;
		u_fmt_t u_fmt;
		j_fmt_t j_fmt;
	} inst_u;

	typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_sel_e;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
		ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASSB
	} alu_sel_e;

	typedef enum logic [1:0] {WB_ALU = 2'd0, WB_MEM = 2'd1, WB_PC4 = 2'd2} wb_sel_e;

	typedef struct packed {
		alu_sel_e alu_sel;
		logic b_sel; // Operand B is the immediate.
		logic a_sel; // Operand A is the pc.
		logic mem_rw; // Store.
		wb_sel_e wb_sel;
		logic br_un; // Unsigned branch compare.
		logic reg_wen;
		logic is_ls;
	} ctrl_t;

	typedef struct packed {
		logic we;
		logic [`RV_REG_AW-1:0] rd;
		logic [`RV_XLEN-1:0] data;
	} wb_t;

	typedef struct packed {
		logic [`RV_XLEN-1:0] rs1;
		logic [`RV_XLEN-1:0] rs2;
		logic [`RV_XLEN-1:0] imm;
		logic [`RV_XLEN-1:0] pc;
		logic [`RV_XLEN-1:0] pc4;
		inst_u inst;
		logic [`RV_REG_AW-1:0] rd;
		logic hit;
		ctrl_t ctrl;
	} id_ex_t;

endpackage

`default_nettype wire

/* rtl/rv_decode_cfg.svh */
`ifndef RV_DECODE_CFG_SVH
`define RV_DECODE_CFG_SVH

// Data path width of the RV32I core.
`define RV_XLEN 32

// Architectural register count.
`define RV_NREGS 32

// Width of a register index in the instruction word.
`define RV_REG_AW 5

`endif
